//--- logic/bp_isa_pkg.sv
////////////////////
// architecture constants shared by the predictor
// pc width, pc word type, instruction step, alignment
////////////////////

`default_nettype none

package bp_isa_pkg;

  localparam int pc_w = 32;          // fetch address width

  typedef logic [pc_w-1:0] pc_t;     // one pc word

  localparam int inst_bytes = 4;     // sequential fetch step
  localparam int align_bits = 2;     // low pc bits, always zero for aligned code

endpackage

`default_nettype wire

//--- logic/bp_types_pkg.sv
////////////////////
// predictor record types
// counter state, resolve and prediction records
////////////////////

`default_nettype none

package bp_types_pkg;

  // 2-bit saturating counter, msb set means predict taken
  typedef enum logic [1:0] {
    strong_nt = 2'b00,              // saturated not taken
    weak_nt   = 2'b01,              // read value of never-written entries
    weak_t    = 2'b10,              // one step into taken
    strong_t  = 2'b11               // saturated taken
  } ctr_t;

  // one branch resolved in the pipeline, valid for a single cycle
  typedef struct packed {
    logic                valid;      // record present this cycle
    logic                is_branch;  // conditional branch, others are ignored
    bp_isa_pkg::pc_t     pc;         // address of the branch itself
    bp_isa_pkg::pc_t     target;     // taken destination
    logic                taken;      // resolved direction
    logic                mispredict; // set by the resolving stage, forces redirect
  } resolve_t;

  // lookup result returned to fetch
  typedef struct packed {
    logic                hit;        // btb tag match on a valid entry
    logic                taken;      // hit and counter in a taken state
    bp_isa_pkg::pc_t     target;     // btb target or pc+4
  } predict_t;

  // direction encoded by a counter state
  function automatic logic ctr_taken(ctr_t ctr);
    return ctr[1];                   // weak_t and strong_t
  endfunction

  // one saturating step of a counter toward the resolved direction
  function automatic ctr_t ctr_step(ctr_t ctr, logic taken);
    ctr_t nxt;
    nxt = ctr;
    if (taken && ctr != strong_t) begin
      nxt = ctr_t'(ctr + 2'd1);      // move toward strong_t
    end else if (!taken && ctr != strong_nt) begin
      nxt = ctr_t'(ctr - 2'd1);      // move toward strong_nt
    end
    return nxt;
  endfunction

endpackage

`default_nettype wire

//--- logic/pred_table.sv
////////////////////
// direct-mapped table, combinational read, clocked write
////////////////////

`timescale 1ns/1ps
`default_nettype none

module pred_table #(
  parameter int  index_w   = 6,      // log2 of entry count
  parameter type payload_t = logic   // what one entry stores
) (
  input  wire               clk,
  input  wire               rst_n,
  input  wire [index_w-1:0] rd_index, // lookup slot
  output logic              rd_valid, // slot written since reset
  output payload_t          rd_data,  // stored payload, undefined when not valid
  input  wire               wr_en,    // write strobe, one entry per edge
  input  wire [index_w-1:0] wr_index, // slot to fill
  input  wire payload_t     wr_data   // payload to store
);

  localparam int depth = 1 << index_w;

  payload_t           mem [depth];   // payload storage
  logic [depth-1:0]   vld;           // one valid bit per slot

  // valid bits are the only control state here
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld <= '0;                     // every slot empty after reset
    end else if (wr_en) begin
      vld[wr_index] <= 1'b1;         // a slot never goes invalid again
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_index] <= wr_data;
    end
  end

  // read is plain indexing, so a write this edge shows up next cycle
  assign rd_valid = vld[rd_index];
  assign rd_data  = mem[rd_index];

  // an unknown write slot would corrupt an arbitrary entry of the table
  a_wr_index_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_en |-> !$isunknown(wr_index)
  ) else $error("pred_table: write with unknown index");

endmodule

`default_nettype wire

//--- logic/btb.sv
////////////////////
// branch target buffer
// index/tag split, hit compare, taken-only fill
////////////////////

`timescale 1ns/1ps
`default_nettype none

module btb #(
  parameter int index_w = 6          // log2 of entry count
) (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire bp_isa_pkg::pc_t        pc,       // fetch address
  input  wire bp_types_pkg::resolve_t resolve,  // training record
  output logic                        hit,      // valid entry with matching tag
  output bp_isa_pkg::pc_t             target    // stored target of the slot
);

  localparam int lo_w  = bp_isa_pkg::align_bits;
  localparam int tag_w = bp_isa_pkg::pc_w - index_w - lo_w; // pc bits above the index

  // entry width follows index_w, so the type lives here
  typedef struct packed {
    logic [tag_w-1:0] tag;           // upper pc bits of the branch
    bp_isa_pkg::pc_t  target;        // taken destination
  } btb_entry_t;

  logic [index_w-1:0] rd_index;      // fetch slot
  logic [tag_w-1:0]   rd_tag;        // fetch tag
  logic               rd_valid;
  btb_entry_t         rd_entry;
  logic               wr_en;         // fill strobe
  logic [index_w-1:0] wr_index;      // slot of the resolved branch
  btb_entry_t         wr_entry;

  assign rd_index = pc[lo_w +: index_w];
  assign rd_tag   = pc[bp_isa_pkg::pc_w-1 -: tag_w];

  // not-taken branches never allocate, so they cannot evict a useful entry
  assign wr_en           = resolve.valid && resolve.is_branch && resolve.taken;
  assign wr_index        = resolve.pc[lo_w +: index_w];
  assign wr_entry.tag    = resolve.pc[bp_isa_pkg::pc_w-1 -: tag_w];
  assign wr_entry.target = resolve.target;

  pred_table #(
    .index_w   (index_w),
    .payload_t (btb_entry_t)
  ) table_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_index (rd_index),
    .rd_valid (rd_valid),
    .rd_data  (rd_entry),
    .wr_en    (wr_en),
    .wr_index (wr_index),
    .wr_data  (wr_entry)
  );

  assign hit    = rd_valid && (rd_entry.tag == rd_tag); // aliasing pcs differ in tag
  assign target = rd_entry.target;

  // a taken fill is seen by the very next lookup of the same branch
  a_fill_visible: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_en |=> (pc != $past(resolve.pc)) || hit
  ) else $error("btb: no hit on the branch filled one edge earlier");

endmodule

`default_nettype wire

//--- logic/bht.sv
////////////////////
// branch history table of 2-bit saturating counters
////////////////////

`timescale 1ns/1ps
`default_nettype none

module bht #(
  parameter int index_w = 6          // log2 of entry count
) (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire bp_isa_pkg::pc_t        pc,       // fetch address
  input  wire bp_types_pkg::resolve_t resolve,  // training record
  output bp_types_pkg::ctr_t          ctr       // counter at the fetch slot
);

  localparam int lo_w = bp_isa_pkg::align_bits;

  logic [index_w-1:0]  rd_index;     // fetch slot
  logic [index_w-1:0]  up_index;     // resolve slot
  logic                rd_valid;
  logic                up_valid;
  bp_types_pkg::ctr_t  rd_raw;       // stored value, undefined when not valid
  bp_types_pkg::ctr_t  up_raw;
  bp_types_pkg::ctr_t  up_old;       // counter before training
  bp_types_pkg::ctr_t  up_new;       // counter after training
  logic                wr_en;

  assign rd_index = pc[lo_w +: index_w];
  assign up_index = resolve.pc[lo_w +: index_w];
  assign wr_en    = resolve.valid && resolve.is_branch; // both directions train

  // fetch copy, read at the fetch slot
  pred_table #(
    .index_w   (index_w),
    .payload_t (bp_types_pkg::ctr_t)
  ) fetch_tbl_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_index (rd_index),
    .rd_valid (rd_valid),
    .rd_data  (rd_raw),
    .wr_en    (wr_en),
    .wr_index (up_index),
    .wr_data  (up_new)
  );

  // training copy, same writes, gives the second read port
  pred_table #(
    .index_w   (index_w),
    .payload_t (bp_types_pkg::ctr_t)
  ) train_tbl_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_index (up_index),
    .rd_valid (up_valid),
    .rd_data  (up_raw),
    .wr_en    (wr_en),
    .wr_index (up_index),
    .wr_data  (up_new)
  );

  // untouched slots behave as weak_nt on both ports
  assign ctr    = rd_valid ? rd_raw : bp_types_pkg::weak_nt;
  assign up_old = up_valid ? up_raw : bp_types_pkg::weak_nt;
  assign up_new = bp_types_pkg::ctr_step(up_old, resolve.taken); // saturates both ends

endmodule

`default_nettype wire

//--- logic/next_pc_sel.sv
////////////////////
// next fetch pc select and combined prediction
////////////////////

`timescale 1ns/1ps
`default_nettype none

module next_pc_sel (
  input  wire bp_isa_pkg::pc_t        pc,         // fetch address
  input  wire                         hit,        // btb hit
  input  wire bp_isa_pkg::pc_t        btb_target, // btb target of the slot
  input  wire bp_types_pkg::ctr_t     ctr,        // direction counter
  input  wire bp_types_pkg::resolve_t resolve,    // resolving stage record
  output bp_types_pkg::predict_t      pred,       // lookup result
  output bp_isa_pkg::pc_t             next_pc     // address fetched next cycle
);

  localparam bp_isa_pkg::pc_t step = bp_isa_pkg::pc_t'(bp_isa_pkg::inst_bytes);
  localparam int lo_w = bp_isa_pkg::align_bits;

  bp_isa_pkg::pc_t seq_pc;           // fall-through of the fetch pc
  bp_isa_pkg::pc_t redirect_pc;      // corrected pc of a mispredicted branch
  logic            taken;
  logic            redirect;

  assign seq_pc = pc + step;
  assign taken  = hit && bp_types_pkg::ctr_taken(ctr); // a miss never predicts taken

  assign pred.hit    = hit;
  assign pred.taken  = taken;
  assign pred.target = taken ? btb_target : seq_pc;

  assign redirect    = resolve.valid && resolve.mispredict;
  assign redirect_pc = resolve.taken ? resolve.target : resolve.pc + step;

  // redirect beats prediction, prediction already folds in pc+4
  always_comb begin
    if (redirect) begin
      next_pc = redirect_pc;
    end else begin
      next_pc = pred.target;
    end
  end

  // aligned fetch stays aligned, so btb fills and resolve targets must be aligned too
  always_comb begin
    if (pc[lo_w-1:0] == '0) begin
      a_next_pc_aligned: assert final (next_pc[lo_w-1:0] == '0)
        else $error("next_pc_sel: misaligned next_pc %h", next_pc);
    end
  end

endmodule

`default_nettype wire

//--- logic/branch_predictor.sv
////////////////////
// branch prediction unit top level
////////////////////

`timescale 1ns/1ps
`default_nettype none

module branch_predictor #(
  parameter int index_w = 6          // 64 entries in each table
) (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire bp_isa_pkg::pc_t        pc,       // fetch address
  input  wire bp_types_pkg::resolve_t resolve,  // one-cycle resolve pulse
  output bp_types_pkg::predict_t      pred,     // same-cycle prediction
  output bp_isa_pkg::pc_t             next_pc   // same-cycle next fetch pc
);

  logic               btb_hit;
  bp_isa_pkg::pc_t    btb_target;
  bp_types_pkg::ctr_t bht_ctr;

  btb #(
    .index_w (index_w)
  ) btb_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .pc      (pc),
    .resolve (resolve),
    .hit     (btb_hit),
    .target  (btb_target)
  );

  bht #(
    .index_w (index_w)
  ) bht_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .pc      (pc),
    .resolve (resolve),
    .ctr     (bht_ctr)
  );

  next_pc_sel next_pc_sel_i (
    .pc         (pc),
    .hit        (btb_hit),
    .btb_target (btb_target),
    .ctr        (bht_ctr),
    .resolve    (resolve),
    .pred       (pred),
    .next_pc    (next_pc)
  );

endmodule

`default_nettype wire

//--- tb/bp_model.svh
////////////////////
// reference model of the predictor
// table storage, predict_ref, train_ref, reset_ref
////////////////////

`ifndef BP_MODEL_SVH
`define BP_MODEL_SVH

localparam int ref_depth = 1 << index_w;     // entries per table
localparam int ref_tag_w = 32 - index_w - 2; // pc bits above the index

// expected outputs of one lookup cycle
typedef struct packed {
  bp_types_pkg::predict_t pred;              // expected lookup result
  bp_isa_pkg::pc_t        next_pc;           // expected next fetch pc
} expect_t;

logic [ref_tag_w-1:0] ref_tag    [ref_depth]; // branch tags
logic                 ref_valid  [ref_depth]; // filled by a taken resolve
bp_isa_pkg::pc_t      ref_target [ref_depth]; // taken destinations
logic [1:0]           ref_ctr    [ref_depth]; // 0 strong nt .. 3 strong t

function automatic logic [index_w-1:0] slot_of(bp_isa_pkg::pc_t addr);
  return addr[2 +: index_w];                 // word aligned index
endfunction

function automatic logic [ref_tag_w-1:0] tag_of(bp_isa_pkg::pc_t addr);
  return addr[31 -: ref_tag_w];
endfunction

task automatic reset_ref();
  for (int i = 0; i < ref_depth; i++) begin
    ref_valid[i]  = 1'b0;
    ref_ctr[i]    = 2'd1;                    // weak not taken
    ref_tag[i]    = '0;
    ref_target[i] = '0;
  end
endtask

// lookup against the current model contents, plus redirect priority
function automatic expect_t predict_ref(bp_isa_pkg::pc_t addr, bp_types_pkg::resolve_t res);
  expect_t            e;
  logic [index_w-1:0] s;
  logic               hit;
  logic               taken;
  s = slot_of(addr);
  hit   = ref_valid[s] && (ref_tag[s] == tag_of(addr));
  taken = hit && ref_ctr[s][1];              // upper half of the counter range
  e.pred.hit    = hit;
  e.pred.taken  = taken;
  e.pred.target = taken ? ref_target[s] : addr + 32'd4;
  if (res.valid && res.mispredict) begin
    e.next_pc = res.taken ? res.target : res.pc + 32'd4; // corrected path
  end else begin
    e.next_pc = e.pred.target;
  end
  return e;
endfunction

// update rules for one resolve at a clock edge
task automatic train_ref(bp_types_pkg::resolve_t res);
  logic [index_w-1:0] s;
  s = slot_of(res.pc);
  if (res.valid && res.is_branch) begin
    if (res.taken) begin
      if (ref_ctr[s] != 2'd3) ref_ctr[s] = ref_ctr[s] + 2'd1;
      ref_valid[s]  = 1'b1;                  // only taken branches allocate
      ref_tag[s]    = tag_of(res.pc);
      ref_target[s] = res.target;
    end else if (ref_ctr[s] != 2'd0) begin
      ref_ctr[s] = ref_ctr[s] - 2'd1;
    end
  end
endtask

`endif

//--- tb/tb_branch_predictor.sv
////////////////////
// testbench for the branch predictor
// directed and random stimulus, model compare, report
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_branch_predictor;

  localparam int index_w        = 6;
  localparam int timeout_cycles = 3000;    // about 2050 cycles of tests plus margin
  localparam int random_cycles  = 2000;

  `include "bp_model.svh"

  logic                    clk;
  logic                    rst_n;
  bp_isa_pkg::pc_t         pc;
  bp_types_pkg::resolve_t  resolve;
  bp_types_pkg::predict_t  pred;
  bp_isa_pkg::pc_t         next_pc;

  int                      errors = 0;
  int                      checks = 0;
  int                      cycles = 0;
  integer                  seed = 70;
  bp_isa_pkg::pc_t         pool [24];      // random fetch addresses
  expect_t                 exp_v;

  branch_predictor #(
    .index_w (index_w)
  ) branch_predictor_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .pc      (pc),
    .resolve (resolve),
    .pred    (pred),
    .next_pc (next_pc)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycles <= cycles + 1;

  // model follows the DUT tables edge by edge
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) reset_ref();
    else train_ref(resolve);
  end

  // every cycle out of reset is compared against the model
  always @(negedge clk) begin
    if (rst_n) begin
      exp_v = predict_ref(pc, resolve);
      checks++;
      if (pred !== exp_v.pred) begin
        errors++;
        $display("FAILED pred: pc %h expected %h actual %h", pc, exp_v.pred, pred);
      end
      if (next_pc !== exp_v.next_pc) begin
        errors++;
        $display("FAILED next_pc: pc %h expected %h actual %h", pc, exp_v.next_pc, next_pc);
      end
    end
  end

  function automatic bp_types_pkg::resolve_t branch_res(bp_isa_pkg::pc_t br_pc,
      bp_isa_pkg::pc_t tgt, logic tk, logic misp);
    bp_types_pkg::resolve_t r;
    r.valid      = 1'b1;
    r.is_branch  = 1'b1;
    r.pc         = br_pc;
    r.target     = tgt;
    r.taken      = tk;
    r.mispredict = misp;
    return r;
  endfunction

  task automatic drive_cycle(input bp_isa_pkg::pc_t fetch_pc, input bp_types_pkg::resolve_t res);
    @(posedge clk);
    pc      <= fetch_pc;
    resolve <= res;
  endtask

  // scenario check with values fixed by the prediction rules
  task automatic expect_lookup(input logic exp_hit, input logic exp_taken,
      input bp_isa_pkg::pc_t exp_next);
    @(negedge clk);
    if (pred.hit !== exp_hit) begin
      errors++;
      $display("FAILED pred.hit: pc %h expected %h actual %h", pc, exp_hit, pred.hit);
    end
    if (pred.taken !== exp_taken) begin
      errors++;
      $display("FAILED pred.taken: pc %h expected %h actual %h", pc, exp_taken, pred.taken);
    end
    if (next_pc !== exp_next) begin
      errors++;
      $display("FAILED next_pc: pc %h expected %h actual %h", pc, exp_next, next_pc);
    end
  endtask

  initial begin
    wait (cycles >= timeout_cycles);
    $display("timeout: stimulus still running after %0d cycles", timeout_cycles);
    $display("checks %0d errors %0d", checks, errors);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    bp_isa_pkg::pc_t        br_a;
    bp_isa_pkg::pc_t        br_b;
    bp_isa_pkg::pc_t        tgt_a;
    bp_isa_pkg::pc_t        tgt_b;
    bp_types_pkg::resolve_t idle;
    bp_types_pkg::resolve_t res;
    logic [4:0]             pick;
    br_a  = 32'h0000_2040;
    br_b  = 32'h0000_2140;                 // same index as br_a, other tag
    tgt_a = 32'h0000_3000;
    tgt_b = 32'h0000_5a0c;
    idle  = '0;
    rst_n   = 1'b0;
    pc      = '0;
    resolve = '0;
    for (int i = 0; i < 24; i++) begin
      // 8 indices, 3 tags each
      pool[i] = bp_isa_pkg::pc_t'(32'h4000 + (i / 8) * 32'h100 + (i % 8) * 12);
    end
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    // empty tables after reset
    for (int i = 0; i < 8; i++) begin
      drive_cycle(bp_isa_pkg::pc_t'(32'h1000 + i * 36), idle);
      expect_lookup(1'b0, 1'b0, bp_isa_pkg::pc_t'(32'h1004 + i * 36));
    end

    // two taken resolves, weak_t then strong_t
    drive_cycle(br_a, branch_res(br_a, tgt_a, 1'b1, 1'b0));
    expect_lookup(1'b0, 1'b0, br_a + 32'd4); // old contents this cycle
    drive_cycle(br_a, idle);
    expect_lookup(1'b1, 1'b1, tgt_a);
    drive_cycle(br_a, branch_res(br_a, tgt_a, 1'b1, 1'b0));
    drive_cycle(br_a, idle);
    expect_lookup(1'b1, 1'b1, tgt_a);

    // hysteresis, two not-taken steps needed to flip
    drive_cycle(br_a, branch_res(br_a, tgt_a, 1'b0, 1'b0));
    drive_cycle(br_a, idle);
    expect_lookup(1'b1, 1'b1, tgt_a);
    drive_cycle(br_a, branch_res(br_a, tgt_a, 1'b0, 1'b0));
    drive_cycle(br_a, idle);
    expect_lookup(1'b1, 1'b0, br_a + 32'd4);

    // aliasing pc misses, then takes over the slot
    drive_cycle(br_b, idle);
    expect_lookup(1'b0, 1'b0, br_b + 32'd4);
    drive_cycle(br_b, branch_res(br_b, tgt_b, 1'b1, 1'b0));
    drive_cycle(br_b, idle);
    expect_lookup(1'b1, 1'b1, tgt_b);
    drive_cycle(br_a, idle);
    expect_lookup(1'b0, 1'b0, br_a + 32'd4);

    // redirect wins over the lookup, which still sees the old entry
    drive_cycle(br_b, branch_res(br_a, tgt_a, 1'b0, 1'b1));
    expect_lookup(1'b1, 1'b1, br_a + 32'd4);
    drive_cycle(br_b, branch_res(br_a, tgt_a, 1'b1, 1'b1));
    expect_lookup(1'b1, 1'b0, tgt_a);      // shared counter back at weak_nt
    drive_cycle(br_b, idle);

    // random mix over a pool with shared indices
    for (int n = 0; n < random_cycles; n++) begin
      res  = '0;
      pick = 5'($unsigned($random(seed)) % 32'd24);
      if ($random(seed) & 1) begin
        res.valid      = 1'b1;
        res.is_branch  = (($random(seed) & 7) != 0);       // mostly branches
        res.pc         = pool[5'($unsigned($random(seed)) % 32'd24)];
        res.target     = bp_isa_pkg::pc_t'($random(seed)) & 32'hffff_fffc;
        res.taken      = (($random(seed) & 1) != 0);
        res.mispredict = (($random(seed) & 3) == 0);
      end
      drive_cycle(pool[pick], res);
    end
    drive_cycle(pool[0], idle);
    @(negedge clk);
    @(negedge clk);

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+tb
logic/bp_isa_pkg.sv
logic/bp_types_pkg.sv
logic/pred_table.sv
logic/btb.sv
logic/bht.sv
logic/next_pc_sel.sv
logic/branch_predictor.sv
tb/tb_branch_predictor.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_branch_predictor
FILELIST = tb.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
